//--- source/vshift_pkg.sv
// Shared widths and types for one 64-bit vector shift lane
// QUEUE_DEPTH must stay a power of two because the queue pointers wrap naturally
package vshift_pkg;

    localparam int LANE_BYTES      = 8;
    localparam int BYTE_WIDTH      = 8;
    localparam int NUM_OSIZES      = 4;                              // E8 up to E64
    localparam int BLOCK_SEL_WIDTH = $clog2(BYTE_WIDTH);             // Bit shift inside a byte
    localparam int BYTE_SEL_WIDTH  = $clog2(LANE_BYTES);             // Whole byte moves
    localparam int SEL_WIDTH       = BLOCK_SEL_WIDTH + BYTE_SEL_WIDTH;
    localparam int QUEUE_DEPTH     = 4;
    localparam int QPTR_WIDTH      = $clog2(QUEUE_DEPTH);
    localparam int QCOUNT_WIDTH    = $clog2(QUEUE_DEPTH + 1);

    typedef logic [LANE_BYTES*BYTE_WIDTH-1:0] lane_data_t;
    typedef logic [BYTE_WIDTH-1:0]            byte_t;
    typedef byte_t [LANE_BYTES-1:0]           byte_vector_t;

    // Bit k stands for an element of 2^k bytes
    typedef logic [NUM_OSIZES-1:0] osize_vector_t;

    // Bit i set when byte i and byte i+1 sit in the same element
    typedef logic [LANE_BYTES-1:0] merge_mask_t;

    // Shift amount as seen by one byte, bit and byte parts together
    typedef logic [SEL_WIDTH-1:0]    sel_t;
    typedef logic [QPTR_WIDTH-1:0]   qptr_t;
    typedef logic [QCOUNT_WIDTH-1:0] qcount_t;

    typedef enum logic [1:0] {
        E8,
        E16,
        E32,
        E64
    } osize_e;

    typedef enum logic [1:0] {
        SLL,
        SRL,
        SRA
    } shift_op_e;

    typedef enum logic {
        EMPTY,
        LOADED
    } req_state_e;

endpackage

//--- source/vshift_req_if.sv
// One decoded shift request between pipeline stages
// valid qualifies every other signal in the same cycle
`timescale 1ns/1ps

interface vshift_req_if;
    import vshift_pkg::*;

    logic          valid;
    logic          is_left;
    logic          is_arith;
    osize_vector_t osize_vector;             // One-hot element size
    osize_vector_t is_less_osize_vector;     // Bit k set when sew <= size k
    osize_vector_t is_greater_osize_vector;  // Bit k set when sew >= size k
    merge_mask_t   merge;
    byte_vector_t  srca;                     // Data to shift
    byte_vector_t  srcb;                     // Shift amounts

    modport source (
        output valid, is_left, is_arith,
        output osize_vector, is_less_osize_vector, is_greater_osize_vector,
        output merge, srca, srcb
    );

    modport sink (
        input valid, is_left, is_arith,
        input osize_vector, is_less_osize_vector, is_greater_osize_vector,
        input merge, srca, srcb
    );

endinterface

//--- source/vshift_decode.sv
// Registers an incoming shift request and builds its control vectors
// A request is never refused here; req.valid pulses once per in_valid
`timescale 1ns/1ps

module vshift_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  vshift_pkg::shift_op_e  op,
    input  vshift_pkg::osize_e     sew,
    input  vshift_pkg::lane_data_t vs2,
    input  vshift_pkg::lane_data_t vs1,
    vshift_req_if.source           req
);
    import vshift_pkg::*;

    req_state_e    state;
    osize_vector_t osize_next;
    osize_vector_t less_next;
    osize_vector_t greater_next;
    merge_mask_t   merge_next;

    // Size vectors and merge mask from sew
    always_comb begin
        for (int k = 0; k < NUM_OSIZES; k++) begin
            osize_next[k]   = (int'(sew) == k);
            less_next[k]    = (int'(sew) <= k);
            greater_next[k] = (int'(sew) >= k);
        end
        for (int i = 0; i < LANE_BYTES; i++) begin
            // Upper byte of an element breaks the chain
            merge_next[i] = (((i + 1) & ((1 << int'(sew)) - 1)) != 0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= EMPTY;
        end else begin
            state <= in_valid ? LOADED : EMPTY;  // Stays LOADED on back to back requests
        end
    end

    assign req.valid = (state == LOADED);

    // Payload only moves on a new request
    always_ff @(posedge clk) begin
        if (in_valid) begin
            req.is_left                 <= (op == SLL);
            req.is_arith                <= (op == SRA);
            req.osize_vector            <= osize_next;
            req.is_less_osize_vector    <= less_next;
            req.is_greater_osize_vector <= greater_next;
            req.merge                   <= merge_next;
            req.srca                    <= vs2;
            req.srcb                    <= vs1;
        end
    end

endmodule

//--- source/vshift_queue.sv
// Four-entry FIFO of decoded shift requests
// A write that meets a full queue is lost and flagged on drop
// The head leaves whenever hold is low, with no handshake from the consumer
`timescale 1ns/1ps

module vshift_queue (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         hold,
    output logic         full,
    output logic         drop,
    vshift_req_if.sink   wr,
    vshift_req_if.source rd
);
    import vshift_pkg::*;

    logic          is_left_mem  [QUEUE_DEPTH];
    logic          is_arith_mem [QUEUE_DEPTH];
    osize_vector_t osize_mem    [QUEUE_DEPTH];
    osize_vector_t less_mem     [QUEUE_DEPTH];
    osize_vector_t greater_mem  [QUEUE_DEPTH];
    merge_mask_t   merge_mem    [QUEUE_DEPTH];
    byte_vector_t  srca_mem     [QUEUE_DEPTH];
    byte_vector_t  srcb_mem     [QUEUE_DEPTH];

    qptr_t   wr_ptr;
    qptr_t   rd_ptr;
    qcount_t count;
    logic    push;
    logic    pop;

    assign full = (count == qcount_t'(QUEUE_DEPTH));
    assign drop = wr.valid & full;
    assign push = wr.valid & ~full;
    assign pop  = (count != '0) & ~hold;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + qcount_t'(push) - qcount_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            is_left_mem[wr_ptr]  <= wr.is_left;
            is_arith_mem[wr_ptr] <= wr.is_arith;
            osize_mem[wr_ptr]    <= wr.osize_vector;
            less_mem[wr_ptr]     <= wr.is_less_osize_vector;
            greater_mem[wr_ptr]  <= wr.is_greater_osize_vector;
            merge_mem[wr_ptr]    <= wr.merge;
            srca_mem[wr_ptr]     <= wr.srca;
            srcb_mem[wr_ptr]     <= wr.srcb;
        end
    end

    // Head entry, consumed in the cycle it is shown
    assign rd.valid                   = pop;
    assign rd.is_left                 = is_left_mem[rd_ptr];
    assign rd.is_arith                = is_arith_mem[rd_ptr];
    assign rd.osize_vector            = osize_mem[rd_ptr];
    assign rd.is_less_osize_vector    = less_mem[rd_ptr];
    assign rd.is_greater_osize_vector = greater_mem[rd_ptr];
    assign rd.merge                   = merge_mem[rd_ptr];
    assign rd.srca                    = srca_mem[rd_ptr];
    assign rd.srcb                    = srcb_mem[rd_ptr];

endmodule

//--- source/byte_shifter.sv
// Shifts one byte by 0 to 7 bits
// shift_in is always the neighbor byte on the vacated side, as exec
// reverses byte order for left shifts
`timescale 1ns/1ps

module byte_shifter (
    input  vshift_pkg::byte_t                      src,
    input  logic [vshift_pkg::BLOCK_SEL_WIDTH-1:0] shift,
    input  logic                                   shift_left,
    input  logic                                   shift_arith,
    input  vshift_pkg::byte_t                      shift_in,
    output vshift_pkg::byte_t                      result
);
    import vshift_pkg::*;

    byte_t                   fill;
    logic [2*BYTE_WIDTH-1:0] right_word;
    logic [2*BYTE_WIDTH-1:0] left_word;

    // Top byte of an element takes sign copies on SRA
    assign fill = shift_arith ? {BYTE_WIDTH{src[BYTE_WIDTH-1]}} : shift_in;

    assign right_word = {fill, src} >> shift;
    assign left_word  = {src, fill} << shift;

    assign result = shift_left ? left_word[2*BYTE_WIDTH-1 -: BYTE_WIDTH]
                               : right_word[BYTE_WIDTH-1:0];

endmodule

//--- source/vshift_exec.sv
// Byte-sliced shifter network with a registered result
// Whole bytes move first in log2 stages, then each byte shifts by 0 to 7 bits
// Left shifts run through the same right-shift network on byte-reversed data
`timescale 1ns/1ps

module vshift_exec (
    input  logic                   clk,
    input  logic                   rst_n,
    vshift_req_if.sink             req,
    output logic                   out_valid,
    output vshift_pkg::lane_data_t result
);
    import vshift_pkg::*;

    byte_vector_t          srca_sel;
    byte_vector_t          srcb_sel;
    merge_mask_t           merge_sel;
    sel_t                  byte_sel  [LANE_BYTES];
    logic [LANE_BYTES-1:0] elem_sign;
    byte_t                 fill_byte [LANE_BYTES];
    byte_vector_t          stage     [BYTE_SEL_WIDTH+1];
    byte_vector_t          shift_in;
    logic [LANE_BYTES-1:0] arith_vec;
    byte_vector_t          shifted;
    byte_vector_t          restored;

    // Largest size level whose alignment idx meets, capped at E64
    function automatic int align_level(int idx);
        int lvl;
        lvl = 0;
        for (int l = 1; l < NUM_OSIZES; l++) begin
            if (idx % (2**l) == 0) lvl = l;
        end
        return lvl;
    endfunction

    // Lowest or highest byte of the element of 2^lvl bytes holding idx
    function automatic int elem_edge(int idx, int lvl, logic upper);
        int span;
        span = 2**lvl - 1;
        return upper ? (idx | span) : (idx & ~span);
    endfunction

    for (genvar j = 0; j < LANE_BYTES; j++) begin : gen_lane
        assign srca_sel[j] = req.is_left ? req.srca[LANE_BYTES-1-j] : req.srca[j];
        assign srcb_sel[j] = req.is_left ? req.srcb[LANE_BYTES-1-j] : req.srcb[j];

        if (j < LANE_BYTES - 1) begin : gen_merge
            assign merge_sel[j] = req.is_left ? req.merge[LANE_BYTES-2-j] : req.merge[j];
        end else begin : gen_merge_top
            assign merge_sel[j] = req.is_left ? 1'b0 : req.merge[j];
        end

        // Amount byte is the element's lowest byte in original order
        always_comb begin
            byte_sel[j] = '0;
            if (req.is_left ? req.is_less_osize_vector[align_level(j + 1)]
                            : req.is_less_osize_vector[align_level(j)]) begin
                byte_sel[j] = srcb_sel[j][SEL_WIDTH-1:0];     // Byte holds its own amount
            end else begin
                for (int k = 1; k < NUM_OSIZES; k++) begin
                    if (req.osize_vector[k]) begin
                        byte_sel[j] = srcb_sel[elem_edge(j, k, req.is_left)][SEL_WIDTH-1:0];
                    end
                end
            end
        end

        always_comb begin
            elem_sign[j] = 1'b0;
            for (int k = 0; k < NUM_OSIZES; k++) begin
                if (req.osize_vector[k]) begin
                    elem_sign[j] = srca_sel[elem_edge(j, k, !req.is_left)][BYTE_WIDTH-1];
                end
            end
        end

        assign fill_byte[j] = {BYTE_WIDTH{req.is_arith & elem_sign[j]}};
    end

    assign stage[0] = srca_sel;

    // Stage k moves bytes down by 2^k when the element is wide enough
    for (genvar k = 0; k < BYTE_SEL_WIDTH; k++) begin : gen_stage
        for (genvar j = 0; j < LANE_BYTES; j++) begin : gen_mux
            if (j + 2**k < LANE_BYTES) begin : gen_inner
                assign stage[k+1][j] =
                    !(byte_sel[j][BLOCK_SEL_WIDTH+k] && req.is_greater_osize_vector[k+1])
                        ? stage[k][j]
                        : (&merge_sel[j +: 2**k]) ? stage[k][j + 2**k] : fill_byte[j];
            end else begin : gen_edge
                // Nothing above the lane, only fill can come in
                assign stage[k+1][j] =
                    (byte_sel[j][BLOCK_SEL_WIDTH+k] && req.is_greater_osize_vector[k+1])
                        ? fill_byte[j] : stage[k][j];
            end
        end
    end

    for (genvar j = 0; j < LANE_BYTES; j++) begin : gen_bits
        if (j < LANE_BYTES - 1) begin : gen_carry
            assign shift_in[j] = merge_sel[j] ? stage[BYTE_SEL_WIDTH][j+1] : '0;
        end else begin : gen_carry_top
            assign shift_in[j] = '0;
        end

        assign arith_vec[j] = ~merge_sel[j] & req.is_arith;   // Element top byte

        byte_shifter i_byte_shifter (
            .src         (stage[BYTE_SEL_WIDTH][j]),
            .shift       (byte_sel[j][BLOCK_SEL_WIDTH-1:0]),
            .shift_left  (req.is_left),
            .shift_arith (arith_vec[j]),
            .shift_in    (shift_in[j]),
            .result      (shifted[j])
        );

        assign restored[j] = req.is_left ? shifted[LANE_BYTES-1-j] : shifted[j];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) result <= restored;
    end

endmodule

//--- source/vshift_top.sv
// Vector shift lane top level, decode then queue then exec
// Latency is 3 cycles with an idle queue and hold low
// Requests arriving while the queue is full are dropped
`timescale 1ns/1ps

module vshift_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  vshift_pkg::shift_op_e  op,
    input  vshift_pkg::osize_e     sew,
    input  vshift_pkg::lane_data_t vs2,     // Data
    input  vshift_pkg::lane_data_t vs1,     // Shift amounts
    input  logic                   hold,
    output logic                   out_valid,
    output vshift_pkg::lane_data_t result,
    output logic                   full,
    output logic                   drop
);

    vshift_req_if dec_q ();
    vshift_req_if q_exec ();

    vshift_decode i_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .op       (op),
        .sew      (sew),
        .vs2      (vs2),
        .vs1      (vs1),
        .req      (dec_q.source)
    );

    vshift_queue i_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .hold  (hold),
        .full  (full),
        .drop  (drop),
        .wr    (dec_q.sink),
        .rd    (q_exec.source)
    );

    vshift_exec i_exec (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (q_exec.sink),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

//--- bench/vshift_checker.sv
// Reference model and result checker for the vector shift lane
// Tracks decode, queue occupancy and exec timing from the lane rules
// Assumes inputs only change just after rising clock edges
`timescale 1ns/1ps

module vshift_checker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  vshift_pkg::shift_op_e  op,
    input  vshift_pkg::osize_e     sew,
    input  vshift_pkg::lane_data_t vs2,
    input  vshift_pkg::lane_data_t vs1,
    input  logic                   hold,
    input  logic                   out_valid,
    input  vshift_pkg::lane_data_t result,
    input  logic                   full,
    input  logic                   drop,
    output logic                   idle,
    output int                     errors,
    output int                     results,
    output int                     drops
);
    import vshift_pkg::*;

    lane_data_t exp_q[$];         // Queued and executing requests, oldest first
    lane_data_t dec_exp;
    lane_data_t expected;
    logic       dec_valid = 1'b0; // Request sitting in decode
    logic       ov_exp    = 1'b0;
    int         qcount    = 0;
    logic       push;
    logic       pop;

    initial begin
        idle    = 1'b0;
        errors  = 0;
        results = 0;
        drops   = 0;
    end

    // Element-wise shift, amount taken modulo the element width
    function automatic lane_data_t expected_shift(shift_op_e sop, osize_e esew,
                                                  lane_data_t data, lane_data_t amt);
        int         ew;
        int         sh;
        lane_data_t mask;
        lane_data_t elem;
        lane_data_t part;
        lane_data_t res;
        ew   = BYTE_WIDTH << int'(esew);
        mask = (ew == LANE_BYTES * BYTE_WIDTH) ? '1 : ((lane_data_t'(1) << ew) - 1);
        res  = '0;
        for (int e = 0; e < (LANE_BYTES * BYTE_WIDTH) / ew; e++) begin
            elem = (data >> (e * ew)) & mask;
            sh   = int'((amt >> (e * ew)) & lane_data_t'(ew - 1));
            part = elem >> sh;
            if (sop == SLL) begin
                part = (elem << sh) & mask;
            end else if (sop == SRA && elem[ew-1]) begin
                part = part | (mask & ~(mask >> sh));   // Sign copies on top
            end
            res = res | (part << (e * ew));
        end
        return res;
    endfunction

    task automatic compare_flag(string name, logic exp_bit, logic act_bit);
        if (act_bit !== exp_bit) begin
            $display("Fail at %0d ns: %s expected %b actual %b", $time, name, exp_bit, act_bit);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            dec_valid = 1'b0;
            ov_exp    = 1'b0;
            qcount    = 0;
        end else begin
            compare_flag("full", qcount == QUEUE_DEPTH, full);
            compare_flag("drop", dec_valid && qcount == QUEUE_DEPTH, drop);
            compare_flag("out_valid", ov_exp, out_valid);
            if (ov_exp) begin
                expected = exp_q.pop_front();
                if (out_valid) begin
                    results++;
                    if (result !== expected) begin
                        $display("Fail at %0d ns: result expected %h actual %h",
                                 $time, expected, result);
                        errors++;
                    end
                end
            end
            push = dec_valid && qcount < QUEUE_DEPTH;
            pop  = qcount > 0 && !hold;
            if (push) exp_q.push_back(dec_exp);
            else if (dec_valid) drops++;
            ov_exp    = pop;                          // Exec registers one cycle later
            qcount    = qcount + int'(push) - int'(pop);
            dec_valid = in_valid;
            if (in_valid) dec_exp = expected_shift(op, sew, vs2, vs1);
        end
        idle = !dec_valid && qcount == 0 && !ov_exp && exp_q.size() == 0;
    end

endmodule

//--- bench/tb_vshift.sv
// Testbench for the vector shift lane
// Each row is sent once, then repeated back to back with random operands
// A row with hold cycles keeps hold high over its requests and that many cycles more
`timescale 1ns/1ps

module tb_vshift;
    import vshift_pkg::*;

    typedef struct {
        shift_op_e  op;
        osize_e     sew;
        lane_data_t vs2;
        lane_data_t vs1;
        int         hold_cycles;
        int         repeats;
    } row_t;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       in_valid;
    shift_op_e  op;
    osize_e     sew;
    lane_data_t vs2;
    lane_data_t vs1;
    logic       hold;
    logic       out_valid;
    lane_data_t result;
    logic       full;
    logic       drop;
    logic       idle;
    int         errors;
    int         results;
    int         drops;
    row_t       rows[$];
    int         limit_cycles;

    always #50 clk = ~clk;

    vshift_top i_dut (.*);

    vshift_checker i_checker (.*);

    task automatic send(shift_op_e s_op, osize_e s_sew, lane_data_t s_vs2, lane_data_t s_vs1);
        @(posedge clk);
        in_valid <= 1'b1;
        op       <= s_op;
        sew      <= s_sew;
        vs2      <= s_vs2;
        vs1      <= s_vs1;
    endtask

    task automatic run_row(row_t r);
        send(r.op, r.sew, r.vs2, r.vs1);
        hold <= (r.hold_cycles > 0);  // Rises with the first request
        repeat (r.repeats) send(r.op, r.sew, {$urandom, $urandom}, {$urandom, $urandom});
        @(posedge clk);
        in_valid <= 1'b0;
        repeat (r.hold_cycles) @(posedge clk);
        hold <= 1'b0;
        do @(negedge clk); while (!idle);
    endtask

    initial begin
        row_t cur;
        int   base_errors;
        int   base_drops;
        void'($urandom(31848));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        op       = SLL;
        sew      = E8;
        vs2      = '0;
        vs1      = '0;
        hold     = 1'b0;

        rows.push_back('{SLL, E8,  64'h0123_4567_89ab_cdef, 64'h0001_0207_0803_0904, 0, 2});
        rows.push_back('{SLL, E16, 64'hfedc_ba98_7654_3210, 64'h000f_0001_0008_0011, 0, 2});
        rows.push_back('{SLL, E32, 64'h8000_0001_1234_5678, 64'h0000_001f_0000_0021, 0, 2});
        rows.push_back('{SLL, E64, 64'h0123_4567_89ab_cdef, 64'h0000_0000_0000_0027, 0, 2});
        rows.push_back('{SRL, E8,  64'h80ff_9c7f_8001_f0a5, 64'h0001_0708_0007_0109, 0, 2});
        rows.push_back('{SRA, E8,  64'h80ff_9c7f_8001_f0a5, 64'h0001_0708_0007_0109, 0, 2});
        rows.push_back('{SRL, E16, 64'h8000_ffff_9234_7fff, 64'h0001_0007_0008_000f, 0, 2});
        rows.push_back('{SRA, E16, 64'h8000_ffff_9234_7fff, 64'h0001_0007_0008_000f, 0, 2});
        rows.push_back('{SRL, E32, 64'h8765_4321_ffff_0000, 64'h0000_001f_0000_0008, 0, 2});
        rows.push_back('{SRA, E32, 64'h8765_4321_ffff_0000, 64'h0000_0001_0000_001f, 0, 2});
        rows.push_back('{SRL, E64, 64'h8000_0000_0000_0001, 64'h0000_0000_0000_003f, 0, 2});
        rows.push_back('{SRA, E64, 64'h8123_4567_89ab_cdef, 64'h0000_0000_0000_0048, 0, 2});
        rows.push_back('{SRA, E64, 64'hf000_0000_0000_0000, 64'h0000_0000_0000_0001, 0, 0});
        rows.push_back('{SRA, E8,  64'h8081_7f7e_ff00_c301, 64'h0701_0800_0309_0102, 4, 4});
        rows.push_back('{SLL, E16, 64'h8001_4002_2004_1008, 64'h0003_0010_000f_0007, 0, 6});
        rows.push_back('{SRA, E32, 64'hc000_0003_7fff_fffe, 64'h0000_0021_0000_0007, 3, 2});

        limit_cycles = 0;
        foreach (rows[i]) limit_cycles += 20 * (1 + rows[i].repeats);

        fork
            begin
                repeat (limit_cycles) @(posedge clk);
                $display("Watchdog expired after %0d cycles, the run did not finish",
                         limit_cycles);
                $display("TEST FAIL");
                $finish;
            end
        join_none

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        foreach (rows[i]) begin
            cur         = rows[i];
            base_errors = errors;
            base_drops  = drops;
            run_row(cur);
            $display("Row %0d %s %s: %0d requests, %0d dropped, %0d errors", i,
                     cur.op.name(), cur.sew.name(), 1 + cur.repeats,
                     drops - base_drops, errors - base_errors);
        end

        $display("Done: %0d rows, %0d results, %0d dropped, %0d errors",
                 rows.size(), results, drops, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
source/vshift_pkg.sv
source/vshift_req_if.sv
source/vshift_decode.sv
source/vshift_queue.sv
source/byte_shifter.sv
source/vshift_exec.sv
source/vshift_top.sv
bench/vshift_checker.sv
bench/tb_vshift.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vshift
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
SIMFLAGS  ?= -Wno-fatal
PASS_TEXT ?= TEST PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) $(SIMFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
